/* logic/cache_ctrl.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Cache controller
// Lookup, line fill and write-through FSM
// ----------------------------------------
`include "cache_settings.svh"

module cache_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cpu_req,
  input  logic                  cpu_we,
  input  cache_pkg::addr_t      cpu_addr,
  input  cache_pkg::word_t      cpu_wdata,
  output logic                  cpu_ack,
  output cache_pkg::word_t      cpu_rdata,
  output logic [`IDX_W-1:0]     tag_rd_idx,
  output logic                  tag_wr_en,
  output logic [`IDX_W-1:0]     tag_wr_idx,
  output cache_pkg::tag_entry_t tag_wr_data,
  input  cache_pkg::tag_entry_t tag_rd_data,
  output logic [`IDX_W-1:0]     data_rd_idx,
  output logic                  data_wr_en,
  output logic [`IDX_W-1:0]     data_wr_idx,
  output cache_pkg::block_t     data_wr_data,
  input  cache_pkg::block_t     data_rd_data,
  output logic                  mem_req,
  output logic                  mem_we,
  output cache_pkg::addr_t      mem_addr,
  output cache_pkg::word_t      mem_wdata,
  input  logic                  mem_ack,
  input  cache_pkg::block_t     mem_rdata
);

  typedef enum logic [2:0] {
    CLEAR,
    IDLE,
    LOOKUP,
    COMPARE,
    MEM_WAIT,
    MEM_RELEASE,
    RESPOND,
    ACK_RELEASE
  } state_t;

  state_t            state;
  logic [`IDX_W-1:0] clr_idx;   // Tag sweep after reset
  cache_pkg::addr_t  addr_q;
  cache_pkg::word_t  wdata_q;
  logic              we_q;
  logic              hit_q;     // Hit seen in compare for the write path

  cache_pkg::tag_t   req_tag;
  logic [`IDX_W-1:0] req_idx;
  logic [`OFF_W-1:0] req_off;
  logic              hit;
  logic              mem_done;  // Memory acknowledge in the wait state
  cache_pkg::block_t merged;

  assign req_tag = addr_q[`ADDR_W-1 -: `TAG_W];
  assign req_idx = addr_q[`OFF_W +: `IDX_W];
  assign req_off = addr_q[`OFF_W-1:0];

  assign hit = tag_rd_data.valid && (tag_rd_data.tag == req_tag);

  // Cached line with the new word put in at the offset
  always_comb begin
    merged          = data_rd_data;
    merged[req_off] = wdata_q;
  end

  // Arrays read the captured index every cycle
  assign tag_rd_idx  = req_idx;
  assign data_rd_idx = req_idx;

  assign mem_done = (state == MEM_WAIT) && mem_ack;

  assign tag_wr_en  = (state == CLEAR) || (mem_done && !we_q);
  assign tag_wr_idx = (state == CLEAR) ? clr_idx : req_idx;

  always_comb begin
    tag_wr_data.valid = (state != CLEAR);
    tag_wr_data.tag   = req_tag;
  end

  // Fill on a read or word merge on a write hit
  assign data_wr_en   = mem_done && (!we_q || hit_q);
  assign data_wr_idx  = req_idx;
  assign data_wr_data = we_q ? merged : mem_rdata;

  assign mem_we    = mem_req && we_q;
  assign mem_addr  = we_q ? addr_q : {addr_q[`ADDR_W-1:`OFF_W], {`OFF_W{1'b0}}};
  assign mem_wdata = wdata_q;

  always_ff @(posedge clk) begin
    if ((state == IDLE) && cpu_req) begin
      addr_q  <= cpu_addr;
      wdata_q <= cpu_wdata;
    end
    if ((state == COMPARE) && hit) begin
      cpu_rdata <= data_rd_data[req_off];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= CLEAR;
      clr_idx <= '0;
      we_q    <= 1'b0;
      hit_q   <= 1'b0;
      cpu_ack <= 1'b0;
      mem_req <= 1'b0;
    end else begin
      case (state)
        CLEAR: begin
          clr_idx <= clr_idx + 1'b1;
          if (clr_idx == '1) begin
            state <= IDLE;
          end
        end
        IDLE: begin
          if (cpu_req) begin
            we_q  <= cpu_we;
            state <= LOOKUP;
          end
        end
        LOOKUP: state <= COMPARE;  // Arrays answer at this edge
        COMPARE: begin
          hit_q <= hit;
          if (hit && !we_q) begin
            cpu_ack <= 1'b1;
            state   <= RESPOND;
          end else begin
            mem_req <= 1'b1;  // Line fetch or write-through
            state   <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= MEM_RELEASE;
          end
        end
        MEM_RELEASE: begin
          if (!mem_ack) begin
            if (we_q) begin
              cpu_ack <= 1'b1;
              state   <= RESPOND;
            end else begin
              state <= LOOKUP;  // Re-read the filled line
            end
          end
        end
        RESPOND: begin
          if (!cpu_req) begin
            state <= ACK_RELEASE;
          end
        end
        ACK_RELEASE: begin
          cpu_ack <= 1'b0;
          state   <= IDLE;
        end
        default: state <= CLEAR;
      endcase
    end
  end

  // Memory request is only withdrawn against an acknowledge
  a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
    $fell(mem_req) |-> mem_ack);

  // Request seen at the edge where the acknowledge went high
  a_cpu_ack_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_ack) |-> $past(cpu_req));

endmodule

/* logic/cache_pkg.sv */
// ----------------------------------------
// Cache types
// Word, address, line and tag formats
// ----------------------------------------
`include "cache_settings.svh"

package cache_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;  // Word address
  typedef logic [`WORD_W-1:0] word_t;

  localparam int unsigned WORDS_PER_LINE = 1 << `OFF_W;

  // One line, word 0 in the low bits
  typedef logic [WORDS_PER_LINE-1:0][`WORD_W-1:0] block_t;

  typedef logic [`TAG_W-1:0] tag_t;

  // Per-line tag entry
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

/* logic/cache_settings.svh */
// ----------------------------------------
// Cache settings
// Sizes of address, word, line and cache, and memory latency
// ----------------------------------------
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Word address width, 4096 words
`define ADDR_W 12

`define WORD_W 32

// Four words per line
`define OFF_W 2

// 16 lines
`define IDX_W 4

// ADDR_W - IDX_W - OFF_W
`define TAG_W 6

`define MEM_LATENCY 4  // Cycles from memory request to acknowledge

`endif

/* logic/cache_top.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Cache subsystem
// Controller, tag and data arrays, backing memory
// ----------------------------------------
`include "cache_settings.svh"

module cache_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             cpu_req,
  input  logic             cpu_we,
  input  cache_pkg::addr_t cpu_addr,
  input  cache_pkg::word_t cpu_wdata,
  output logic             cpu_ack,
  output cache_pkg::word_t cpu_rdata
);

  logic [`IDX_W-1:0]     tag_rd_idx;
  logic                  tag_wr_en;
  logic [`IDX_W-1:0]     tag_wr_idx;
  cache_pkg::tag_entry_t tag_wr_data;
  cache_pkg::tag_entry_t tag_rd_data;

  logic [`IDX_W-1:0]     data_rd_idx;
  logic                  data_wr_en;
  logic [`IDX_W-1:0]     data_wr_idx;
  cache_pkg::block_t     data_wr_data;
  cache_pkg::block_t     data_rd_data;

  logic                  mem_req;
  logic                  mem_we;
  cache_pkg::addr_t      mem_addr;
  cache_pkg::word_t      mem_wdata;
  logic                  mem_ack;
  cache_pkg::block_t     mem_rdata;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cpu_req      (cpu_req),
    .cpu_we       (cpu_we),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_ack      (cpu_ack),
    .cpu_rdata    (cpu_rdata),
    .tag_rd_idx   (tag_rd_idx),
    .tag_wr_en    (tag_wr_en),
    .tag_wr_idx   (tag_wr_idx),
    .tag_wr_data  (tag_wr_data),
    .tag_rd_data  (tag_rd_data),
    .data_rd_idx  (data_rd_idx),
    .data_wr_en   (data_wr_en),
    .data_wr_idx  (data_wr_idx),
    .data_wr_data (data_wr_data),
    .data_rd_data (data_rd_data),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

  line_ram #(.payload_t(cache_pkg::tag_entry_t), .DEPTH_W(`IDX_W)) tag_ram (
    .clk     (clk),
    .rd_idx  (tag_rd_idx),
    .rd_data (tag_rd_data),
    .wr_en   (tag_wr_en),
    .wr_idx  (tag_wr_idx),
    .wr_data (tag_wr_data)
  );

  line_ram #(.payload_t(cache_pkg::block_t), .DEPTH_W(`IDX_W)) data_ram (
    .clk     (clk),
    .rd_idx  (data_rd_idx),
    .rd_data (data_rd_data),
    .wr_en   (data_wr_en),
    .wr_idx  (data_wr_idx),
    .wr_data (data_wr_data)
  );

  mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

/* logic/line_ram.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Line RAM
// Line-indexed array, registered read and one write port
// ----------------------------------------
module line_ram #(
  parameter type payload_t = logic,
  parameter int  DEPTH_W   = 4
) (
  input  logic               clk,
  input  logic [DEPTH_W-1:0] rd_idx,
  output payload_t           rd_data,
  input  logic               wr_en,
  input  logic [DEPTH_W-1:0] wr_idx,
  input  payload_t           wr_data
);

  payload_t store [1 << DEPTH_W];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      store[wr_idx] <= wr_data;
    end
    rd_data <= store[rd_idx];  // Old value when the write hits the same index
  end

endmodule

/* logic/mem_model.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Memory model
// Line reads and word writes after a fixed latency
// ----------------------------------------
`include "cache_settings.svh"

module mem_model (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_req,
  input  logic              mem_we,
  input  cache_pkg::addr_t  mem_addr,
  input  cache_pkg::word_t  mem_wdata,
  output logic              mem_ack,
  output cache_pkg::block_t mem_rdata
);

  localparam int DEPTH = 1 << `ADDR_W;
  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  typedef logic [`OFF_W-1:0] off_t;

  cache_pkg::word_t mem [DEPTH];
  logic [CNT_W-1:0] cnt;
  logic             busy;
  logic             fire;  // Latency elapsed, access happens now

  assign fire = busy && (cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      mem_ack <= 1'b0;
    end else if (fire) begin
      busy    <= 1'b0;
      mem_ack <= 1'b1;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end else if (mem_ack) begin
      if (!mem_req) begin
        mem_ack <= 1'b0;  // Hold until the request is withdrawn
      end
    end else if (mem_req) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(`MEM_LATENCY - 1);
    end
  end

  // Reset contents follow address XOR A5A5 in the upper half
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= cache_pkg::word_t'(32'hA5A5_0000) ^ cache_pkg::word_t'(i);
      end
    end else if (fire) begin
      if (mem_we) begin
        mem[mem_addr] <= mem_wdata;
      end else begin
        for (int w = 0; w < int'(cache_pkg::WORDS_PER_LINE); w++) begin
          mem_rdata[w] <= mem[{mem_addr[`ADDR_W-1:`OFF_W], off_t'(w)}];
        end
      end
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_ack) |-> mem_req);

endmodule

/* project.f */
+incdir+logic
logic/cache_pkg.sv
logic/line_ram.sv
logic/cache_ctrl.sv
logic/mem_model.sv
logic/cache_top.sv
tb/tb_cache_top.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_cache_top || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_cache_top)
echo "$out"
echo "$out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

/* tb/tb_cache_top.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Cache testbench
// Directed and random accesses checked against a shadow memory
// ----------------------------------------
`include "cache_settings.svh"

module tb_cache_top;

  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 300;
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 50;  // Reset and tag sweep margin
  localparam int DEPTH      = 1 << `ADDR_W;

  logic             clk;
  logic             rst;
  logic             cpu_req;
  logic             cpu_we;
  cache_pkg::addr_t cpu_addr;
  cache_pkg::word_t cpu_wdata;
  logic             cpu_ack;
  cache_pkg::word_t cpu_rdata;

  cache_pkg::word_t shadow  [DEPTH];
  logic             written [DEPTH];  // Word has been written since reset
  logic [31:0]      rng;
  int               errors;
  int               checks;
  int               cycle_count;

  // Accesses in flight, oldest first
  logic             pend_we  [$];
  cache_pkg::word_t pend_exp [$];
  logic             cmp_we;
  cache_pkg::word_t cmp_exp;
  logic             ack_seen = 1'b0;

  cache_top dut (
    .clk       (clk),
    .rst       (rst),
    .cpu_req   (cpu_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Expected read word, memory reset rule unless written since
  function automatic cache_pkg::word_t ref_read(input cache_pkg::addr_t a);
    return written[a] ? shadow[a] : (32'hA5A5_0000 ^ 32'(a));
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // One four-phase access, lat counts cycles from the req sample edge to ack
  task automatic access(input logic we, input cache_pkg::addr_t addr,
                        input cache_pkg::word_t wdata, output int lat);
    int waited;
    waited = 0;
    pend_we.push_back(we);
    pend_exp.push_back(ref_read(addr));
    if (we) begin
      shadow[addr]  = wdata;
      written[addr] = 1'b1;
    end
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_req   = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!cpu_ack);
    lat     = waited - 1;
    cpu_req = 1'b0;
    @(negedge clk);
    check("cpu_ack", 32'(cpu_ack), 32'h1);  // Drop is seen one edge later
    @(negedge clk);
    check("cpu_ack", 32'(cpu_ack), 32'h0);
  endtask

  // Compare read data on each rising ack
  always @(negedge clk) begin
    if (cpu_ack && !ack_seen) begin
      if (pend_we.size() == 0) begin
        errors++;
        $display("cpu_ack rose with no access outstanding at %0t", $time);
      end else begin
        cmp_we  = pend_we.pop_front();
        cmp_exp = pend_exp.pop_front();
        if (!cmp_we) begin
          check("cpu_rdata", cpu_rdata, cmp_exp);
        end
      end
    end
    ack_seen = cpu_ack;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, checks %0d, errors %0d", cycle_count, checks, errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int               lat;
    logic             we;
    cache_pkg::addr_t a;
    errors    = 0;
    checks    = 0;
    rng       = 32'h8838;
    cpu_req   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    for (int i = 0; i < DEPTH; i++) begin
      written[i] = 1'b0;
    end
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    access(1'b0, 12'h123, '0, lat);  // Cold miss, reset pattern
    access(1'b0, 12'h123, '0, lat);
    check("read_hit_latency", lat, 2);

    access(1'b1, 12'h122, 32'hDEAD_BEEF, lat);  // Write hit
    access(1'b0, 12'h122, '0, lat);
    check("read_hit_latency", lat, 2);
    access(1'b1, 12'h7F0, 32'h1234_5678, lat);  // Write miss, no allocate
    access(1'b0, 12'h7F0, '0, lat);

    // Same index, two tags
    access(1'b0, 12'h045, '0, lat);
    access(1'b0, 12'h445, '0, lat);
    access(1'b0, 12'h045, '0, lat);
    check("evicted_reread_over_2", 32'(lat > 2), 32'h1);
    access(1'b0, 12'h445, '0, lat);
    check("evicted_reread_over_2", 32'(lat > 2), 32'h1);

    for (int n = 0; n < N_RANDOM; n++) begin
      rng = xorshift(rng);
      a   = {rng[1:0], 4'b0000, rng[7:2]};  // Four tags over every index and offset
      we  = rng[8];
      rng = xorshift(rng);
      access(we, a, rng, lat);
    end

    if (pend_we.size() != 0) begin
      errors++;
      $display("%0d accesses never got an acknowledge", pend_we.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
